// File: hw/dbg_char_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_char_streamer (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_clk_en,
    input  logic [3:0]                    i_phases,
    input  logic                          i_instr_decoded,
    input  logic                          i_format_done,
    input  logic [dbg_pkg::DBG_PTR_W-1:0] i_length,
    input  logic [7:0]                    i_rd_char,
    output logic                          o_start,
    output logic                          o_clear,
    output logic [dbg_pkg::DBG_PTR_W-1:0] o_rd_addr,
    output logic                          o_debug_cycle,
    output logic                          o_char_strobe,
    output logic [7:0]                    o_char_to_send
);
    import dbg_pkg::*;

    logic [1:0]           cycle_state;
    logic                 start_q;
    logic [DBG_PTR_W-1:0] rd_cnt;
    logic                 trigger;
    logic                 advance;

    assign trigger = (cycle_state == CYC_IDLE) && i_clk_en && i_phases[3] && i_instr_decoded;
    assign advance = (cycle_state == CYC_DRAIN) && i_clk_en && (rd_cnt != i_length);

    // address the buffer one step ahead, so i_rd_char always holds
    // the character at rd_cnt.
    assign o_rd_addr = advance ? (rd_cnt + 1'b1) : rd_cnt;

    assign o_start       = start_q;
    assign o_clear       = start_q;
    assign o_debug_cycle = (cycle_state != CYC_IDLE);

    // ======================================================================
    // debug cycle: idle, format, drain.
    // ======================================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cycle_state    <= CYC_IDLE;
            start_q        <= 1'b0;
            rd_cnt         <= '0;
            o_char_strobe  <= 1'b0;
            o_char_to_send <= 8'h00;
        end else begin
            start_q       <= trigger;
            o_char_strobe <= advance;
            if (advance) begin
                o_char_to_send <= i_rd_char;
                rd_cnt         <= rd_cnt + 1'b1;
            end
            case (cycle_state)
                CYC_IDLE: begin
                    if (trigger) begin
                        cycle_state <= CYC_FORMAT;
                        rd_cnt      <= '0;
                    end
                end
                CYC_FORMAT: if (i_format_done) cycle_state <= CYC_DRAIN;
                // last strobe is out, drop the cycle on the next clock.
                CYC_DRAIN:  if (rd_cnt == i_length) cycle_state <= CYC_IDLE;
                default:    cycle_state <= CYC_IDLE;
            endcase
        end
    end

    a_strobe_in_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        o_char_strobe |-> o_debug_cycle);

endmodule

`default_nettype wire

// File: hw/dbg_field_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_field_sequencer (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_start,
    output dbg_pkg::dbg_token_u o_token,
    output logic               o_literal,
    output logic               o_valid,
    output logic               o_done
);
    import dbg_pkg::*;

    logic [3:0]           field;
    logic [4:0]           chr_idx;
    logic [63:0]          lbl_text;
    logic [2:0]           val_src;
    logic [DBG_PTR_W-1:0] tok_cnt;

    // number of characters in a field.
    function automatic logic [4:0] field_len(input logic [3:0] f);
        case (f)
            FLD_PC_LBL:  return 5'd4;
            FLD_PC_VAL:  return 5'd5;
            FLD_CY_LBL:  return 5'd8;
            FLD_P_LBL:   return 5'd3;
            FLD_HST_LBL: return 5'd6;
            FLD_HST_VAL: return 5'd4;
            FLD_ST_LBL:  return 5'd5;
            FLD_ST_VAL:  return 5'd16;
            FLD_C_LBL:   return 5'd3;
            FLD_C_VAL:   return 5'd16;
            default:     return 5'd1;
        endcase
    endfunction

    // ======================================================================
    // current field decode.
    // ======================================================================
    // labels are right justified in lbl_text, so the index counting down
    // picks them left to right.
    always_comb begin
        lbl_text  = '0;
        val_src   = SRC_PC;
        o_literal = 1'b1;
        case (field)
            FLD_PC_LBL:  lbl_text = "PC: ";
            FLD_CY_LBL:  lbl_text = " Carry: ";
            FLD_P_LBL:   lbl_text = "P: ";
            FLD_HST_LBL: lbl_text = " HST: ";
            FLD_ST_LBL:  lbl_text = " ST: ";
            FLD_C_LBL:   lbl_text = "C: ";
            FLD_NL_0, FLD_NL_1, FLD_NL_2: lbl_text = "\n";
            FLD_PC_VAL:  begin o_literal = 1'b0; val_src = SRC_PC;    end
            FLD_CY_VAL:  begin o_literal = 1'b0; val_src = SRC_CARRY; end
            FLD_P_VAL:   begin o_literal = 1'b0; val_src = SRC_P;     end
            FLD_HST_VAL: begin o_literal = 1'b0; val_src = SRC_HST;   end
            FLD_ST_VAL:  begin o_literal = 1'b0; val_src = SRC_ST;    end
            FLD_C_VAL:   begin o_literal = 1'b0; val_src = SRC_REG;   end
            default:     lbl_text = '0;
        endcase
    end

    always_comb begin
        o_token = '0;
        if (o_literal) begin
            o_token.ascii = lbl_text[{chr_idx[2:0], 3'b000} +: 8];
        end else begin
            o_token.nibref.src = val_src;
            o_token.nibref.idx = chr_idx;
        end
    end

    assign o_valid = (field != FLD_IDLE);

    // ======================================================================
    // field walk, one token per clock.
    // ======================================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            field   <= FLD_IDLE;
            chr_idx <= '0;
            tok_cnt <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                field   <= FLD_PC_LBL;
                chr_idx <= field_len(FLD_PC_LBL) - 5'd1;
                tok_cnt <= '0;
            end else if (o_valid) begin
                tok_cnt <= tok_cnt + 1'b1;
                if (chr_idx != 5'd0) begin
                    chr_idx <= chr_idx - 5'd1;
                end else if (field == FLD_NL_2) begin
                    field  <= FLD_IDLE;
                    o_done <= 1'b1;
                end else begin
                    field   <= field + 4'd1;
                    chr_idx <= field_len(field + 4'd1) - 5'd1;
                end
            end
        end
    end

    // the layout must add up to exactly one dump.
    a_token_count: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid |-> (tok_cnt < DBG_PTR_W'(DBG_TEXT_LEN)));
    a_done_count: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |-> (tok_cnt == DBG_PTR_W'(DBG_TEXT_LEN)));

endmodule

`default_nettype wire

// File: hw/dbg_nibble_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_nibble_formatter (
    input  dbg_pkg::dbg_token_u i_token,
    input  logic               i_literal,
    input  logic               i_valid,
    input  logic [19:0]        i_current_pc,
    input  logic               i_carry,
    input  logic [3:0]         i_reg_p,
    input  logic [3:0]         i_reg_hst,
    input  logic [15:0]        i_reg_st,
    input  logic [3:0]         i_dbg_reg_nibble,
    output logic [4:0]         o_dbg_register,
    output logic [3:0]         o_dbg_reg_ptr,
    output logic [7:0]         o_char,
    output logic               o_write
);
    import dbg_pkg::*;

    logic [3:0] nibble;
    logic [7:0] hex_char;
    logic [4:0] ref_idx;
    logic [4:0] idx_limit;

    assign ref_idx = i_token.nibref.idx;

    // pick the referenced nibble.
    // single bits come out as 0 or 1.
    always_comb begin
        nibble         = 4'h0;
        o_dbg_register = ALU_REG_NONE;
        o_dbg_reg_ptr  = 4'h0;
        if (i_valid && !i_literal) begin
            case (i_token.nibref.src)
                SRC_PC:    nibble = i_current_pc[{ref_idx[2:0], 2'b00} +: 4];
                SRC_CARRY: nibble = {3'b000, i_carry};
                SRC_P:     nibble = i_reg_p;
                SRC_HST:   nibble = {3'b000, i_reg_hst[ref_idx[1:0]]};
                SRC_ST:    nibble = {3'b000, i_reg_st[ref_idx[3:0]]};
                SRC_REG: begin
                    // register file answers in the same cycle.
                    o_dbg_register = ALU_REG_C;
                    o_dbg_reg_ptr  = ref_idx[3:0];
                    nibble         = i_dbg_reg_nibble;
                end
                default:   nibble = 4'h0;
            endcase
        end
    end

    assign hex_char = (nibble < 4'd10) ? (8'h30 + {4'h0, nibble})
                                       : (8'h37 + {4'h0, nibble});

    assign o_char  = i_literal ? i_token.ascii : hex_char;
    assign o_write = i_valid;

    // digits each source can supply.
    always_comb begin
        case (i_token.nibref.src)
            SRC_PC:          idx_limit = 5'd5;
            SRC_HST:         idx_limit = 5'd4;
            SRC_ST, SRC_REG: idx_limit = 5'd16;
            default:         idx_limit = 5'd1;
        endcase
    end

    // a reference past the end of its source would read the wrong bits.
    always_comb begin
        if (i_valid && !i_literal) begin
            a_idx_in_range: assert (ref_idx < idx_limit);
        end
    end

endmodule

`default_nettype wire

// File: hw/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    // ======================================================================
    // layout and sizing.
    // ======================================================================
    localparam int DBG_TEXT_LEN  = 75;
    localparam int DBG_BUF_DEPTH = 128;
    localparam int DBG_PTR_W     = 7;

    // register codes on the register file read port.
    localparam logic [4:0] ALU_REG_C    = 5'd2;
    localparam logic [4:0] ALU_REG_NONE = 5'd31;

    // sources a value digit can be taken from.
    localparam logic [2:0] SRC_PC    = 3'd0;
    localparam logic [2:0] SRC_CARRY = 3'd1;
    localparam logic [2:0] SRC_P     = 3'd2;
    localparam logic [2:0] SRC_HST   = 3'd3;
    localparam logic [2:0] SRC_ST    = 3'd4;
    localparam logic [2:0] SRC_REG   = 3'd5;

    // ======================================================================
    // fields of the dump, in print order.
    // ======================================================================
    localparam logic [3:0] FLD_IDLE    = 4'd0;
    localparam logic [3:0] FLD_PC_LBL  = 4'd1;
    localparam logic [3:0] FLD_PC_VAL  = 4'd2;
    localparam logic [3:0] FLD_CY_LBL  = 4'd3;
    localparam logic [3:0] FLD_CY_VAL  = 4'd4;
    localparam logic [3:0] FLD_NL_0    = 4'd5;
    localparam logic [3:0] FLD_P_LBL   = 4'd6;
    localparam logic [3:0] FLD_P_VAL   = 4'd7;
    localparam logic [3:0] FLD_HST_LBL = 4'd8;
    localparam logic [3:0] FLD_HST_VAL = 4'd9;
    localparam logic [3:0] FLD_ST_LBL  = 4'd10;
    localparam logic [3:0] FLD_ST_VAL  = 4'd11;
    localparam logic [3:0] FLD_NL_1    = 4'd12;
    localparam logic [3:0] FLD_C_LBL   = 4'd13;
    localparam logic [3:0] FLD_C_VAL   = 4'd14;
    localparam logic [3:0] FLD_NL_2    = 4'd15;

    // debug cycle states.
    localparam logic [1:0] CYC_IDLE   = 2'd0;
    localparam logic [1:0] CYC_FORMAT = 2'd1;
    localparam logic [1:0] CYC_DRAIN  = 2'd2;

    // a value digit: where it comes from and which digit or bit.
    typedef struct packed {
        logic [2:0] src;
        logic [4:0] idx;
    } dbg_nibref_t;

    // one token word, either a literal character or a digit reference.
    typedef union packed {
        logic [7:0]  ascii;
        dbg_nibref_t nibref;
    } dbg_token_u;

endpackage

`default_nettype wire

// File: hw/dbg_text_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_text_buffer (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_clear,
    input  logic                          i_write,
    input  logic [7:0]                    i_char,
    input  logic [dbg_pkg::DBG_PTR_W-1:0] i_rd_addr,
    output logic [7:0]                    o_rd_char,
    output logic [dbg_pkg::DBG_PTR_W-1:0] o_length
);
    import dbg_pkg::*;

    logic [7:0] mem [DBG_BUF_DEPTH];

    // character store, registered read.
    always_ff @(posedge i_clk) begin
        if (i_write && !i_clear) begin
            mem[o_length] <= i_char;
        end
        o_rd_char <= mem[i_rd_addr];
    end

    // append pointer.
    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            o_length <= '0;
        end else if (i_write) begin
            o_length <= o_length + 1'b1;
        end
    end

    // a write into a full buffer would wrap the length back to zero.
    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_write && !i_clear) |=> (o_length != '0));

endmodule

`default_nettype wire

// File: hw/saturn_debugger.sv
`timescale 1ns/1ps
`default_nettype none

module saturn_debugger (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_clk_en,
    input  logic [3:0]  i_phases,
    input  logic        i_instr_decoded,
    input  logic [19:0] i_current_pc,
    input  logic        i_carry,
    input  logic [3:0]  i_reg_p,
    input  logic [3:0]  i_reg_hst,
    input  logic [15:0] i_reg_st,
    input  logic [3:0]  i_dbg_reg_nibble,
    output logic        o_debug_cycle,
    output logic [4:0]  o_dbg_register,
    output logic [3:0]  o_dbg_reg_ptr,
    output logic [7:0]  o_char_to_send,
    output logic        o_char_strobe
);
    import dbg_pkg::*;

    dbg_token_u           token;
    logic                 token_literal;
    logic                 token_valid;
    logic                 format_done;
    logic                 seq_start;
    logic                 buf_clear;
    logic [7:0]           fmt_char;
    logic                 fmt_write;
    logic [7:0]           rd_char;
    logic [DBG_PTR_W-1:0] rd_addr;
    logic [DBG_PTR_W-1:0] text_length;

    // ======================================================================
    // format path.
    // ======================================================================
    dbg_field_sequencer dbg_field_sequencer_inst (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (seq_start),
        .o_token   (token),
        .o_literal (token_literal),
        .o_valid   (token_valid),
        .o_done    (format_done)
    );

    dbg_nibble_formatter dbg_nibble_formatter_inst (
        .i_token          (token),
        .i_literal        (token_literal),
        .i_valid          (token_valid),
        .i_current_pc     (i_current_pc),
        .i_carry          (i_carry),
        .i_reg_p          (i_reg_p),
        .i_reg_hst        (i_reg_hst),
        .i_reg_st         (i_reg_st),
        .i_dbg_reg_nibble (i_dbg_reg_nibble),
        .o_dbg_register   (o_dbg_register),
        .o_dbg_reg_ptr    (o_dbg_reg_ptr),
        .o_char           (fmt_char),
        .o_write          (fmt_write)
    );

    dbg_text_buffer dbg_text_buffer_inst (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_clear   (buf_clear),
        .i_write   (fmt_write),
        .i_char    (fmt_char),
        .i_rd_addr (rd_addr),
        .o_rd_char (rd_char),
        .o_length  (text_length)
    );

    // output side.
    dbg_char_streamer dbg_char_streamer_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_clk_en        (i_clk_en),
        .i_phases        (i_phases),
        .i_instr_decoded (i_instr_decoded),
        .i_format_done   (format_done),
        .i_length        (text_length),
        .i_rd_char       (rd_char),
        .o_start         (seq_start),
        .o_clear         (buf_clear),
        .o_rd_addr       (rd_addr),
        .o_debug_cycle   (o_debug_cycle),
        .o_char_strobe   (o_char_strobe),
        .o_char_to_send  (o_char_to_send)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the saturn_debugger testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_saturn_debugger

if ! verilator --binary --timing --assert -j 0 \
        --top-module "$TOP" -Mdir obj_dir -f sources.f; then
    echo "build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: sources.f
hw/dbg_pkg.sv
hw/dbg_field_sequencer.sv
hw/dbg_nibble_formatter.sv
hw/dbg_text_buffer.sv
hw/dbg_char_streamer.sv
hw/saturn_debugger.sv
tb/tb_saturn_debugger.sv

// File: tb/tb_saturn_debugger.sv
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_debugger;
    import dbg_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int N_DUMPS        = 4;
    localparam int TIMEOUT_CYCLES = N_DUMPS * 75 * 4 + 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        clk_en;
    logic [3:0]  phases;
    logic        instr_decoded;
    logic [19:0] current_pc;
    logic        carry;
    logic [3:0]  reg_p;
    logic [3:0]  reg_hst;
    logic [15:0] reg_st;
    logic [3:0]  dbg_reg_nibble;
    logic        debug_cycle;
    logic [4:0]  dbg_register;
    logic [3:0]  dbg_reg_ptr;
    logic [7:0]  char_to_send;
    logic        char_strobe;

    logic [63:0] c_value;
    logic [7:0]  exp_q[$];
    logic [7:0]  exp_char;
    logic [3:0]  exp_ptr;
    logic [31:0] rnd;
    logic        en_q;
    integer      seed;
    int          strobe_cnt;
    int          c_reads;
    int          mismatch_count;
    int          failure_count;

    saturn_debugger saturn_debugger_inst (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_clk_en         (clk_en),
        .i_phases         (phases),
        .i_instr_decoded  (instr_decoded),
        .i_current_pc     (current_pc),
        .i_carry          (carry),
        .i_reg_p          (reg_p),
        .i_reg_hst        (reg_hst),
        .i_reg_st         (reg_st),
        .i_dbg_reg_nibble (dbg_reg_nibble),
        .o_debug_cycle    (debug_cycle),
        .o_dbg_register   (dbg_register),
        .o_dbg_reg_ptr    (dbg_reg_ptr),
        .o_char_to_send   (char_to_send),
        .o_char_strobe    (char_strobe)
    );

    // register file model answers in the same cycle.
    assign dbg_reg_nibble = (dbg_register == ALU_REG_C) ? c_value[{dbg_reg_ptr, 2'b00} +: 4]
                                                         : 4'h0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // clock enable as seen by the DUT at each edge.
    always @(posedge clk) en_q <= clk_en;

    task automatic flag_failure(input string msg);
        failure_count++;
        $display("error at time %0t: %s", $time, msg);
    endtask

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("mismatch at time %0t: %s", $time, msg);
    endtask

    // ======================================================================
    // output checks on the falling edge.
    // ======================================================================
    always @(negedge clk) begin
        if (reset) begin
            assert (!debug_cycle && !char_strobe && dbg_register == ALU_REG_NONE
                    && char_to_send == 8'h00)
            else flag_failure("outputs are not idle during reset");
        end else begin
            if (dbg_register != ALU_REG_NONE) begin
                assert (dbg_register == ALU_REG_C)
                else flag_failure("register port asked for a register other than C");
                assert (dbg_reg_ptr == exp_ptr)
                else report_mismatch($sformatf("register pointer expected %0d, got %0d",
                                               exp_ptr, dbg_reg_ptr));
                exp_ptr = exp_ptr - 4'd1;
                c_reads++;
            end
            if (char_strobe) begin
                strobe_cnt++;
                assert (en_q) else flag_failure("strobe without clock enable before it");
                assert (debug_cycle) else flag_failure("strobe outside a debug cycle");
                assert (exp_q.size() != 0) else flag_failure("strobe after the dump was complete");
                if (exp_q.size() != 0) begin
                    exp_char = exp_q.pop_front();
                    assert (char_to_send == exp_char)
                    else report_mismatch($sformatf("char %0d expected 0x%02h, got 0x%02h",
                                                   strobe_cnt, exp_char, char_to_send));
                end
            end
        end
    end

    // ======================================================================
    // expected text from the layout rule.
    // ======================================================================
    function automatic logic [7:0] hex_digit(input logic [3:0] n);
        if (n < 4'd10) return 8'h30 + {4'h0, n};
        return 8'h41 + {4'h0, n - 4'd10};
    endfunction

    task automatic push_str(input string s);
        for (int i = 0; i < s.len(); i++) exp_q.push_back(s[i]);
    endtask

    task automatic build_expected();
        exp_q.delete();
        push_str("PC: ");
        for (int i = 4; i >= 0; i--) exp_q.push_back(hex_digit(current_pc[i*4 +: 4]));
        push_str(" Carry: ");
        exp_q.push_back(hex_digit({3'b000, carry}));
        push_str("\nP: ");
        exp_q.push_back(hex_digit(reg_p));
        push_str(" HST: ");
        for (int i = 3; i >= 0; i--) exp_q.push_back(hex_digit({3'b000, reg_hst[i]}));
        push_str(" ST: ");
        for (int i = 15; i >= 0; i--) exp_q.push_back(hex_digit({3'b000, reg_st[i]}));
        push_str("\nC: ");
        for (int i = 15; i >= 0; i--) exp_q.push_back(hex_digit(c_value[i*4 +: 4]));
        push_str("\n");
    endtask

    // ======================================================================
    // stimulus.
    // ======================================================================
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_idle();
        clk_en        = 1'b0;
        phases        = 4'h0;
        instr_decoded = 1'b0;
    endtask

    task automatic randomize_state();
        rnd = $random(seed);
        current_pc = rnd[19:0];
        carry      = rnd[20];
        reg_p      = rnd[27:24];
        rnd = $random(seed);
        reg_st  = rnd[15:0];
        reg_hst = rnd[19:16];
        rnd = $random(seed);
        c_value[63:32] = rnd;
        rnd = $random(seed);
        c_value[31:0] = rnd;
    endtask

    task automatic fire_trigger();
        clk_en        = 1'b1;
        phases        = 4'b1000;
        instr_decoded = 1'b1;
        tick();
        phases        = 4'h0;
        instr_decoded = 1'b0;
        assert (debug_cycle) else flag_failure("valid trigger did not start a debug cycle");
    endtask

    // one full dump with optional stray triggers while the cycle runs.
    task automatic run_dump(input logic throttle, input logic stray);
        randomize_state();
        build_expected();
        strobe_cnt = 0;
        c_reads    = 0;
        exp_ptr    = 4'hf;
        fire_trigger();
        while (debug_cycle) begin
            rnd = $random(seed);
            clk_en        = throttle ? rnd[0] : 1'b1;
            instr_decoded = stray & rnd[1];
            phases        = {stray & rnd[2], 3'b000};
            tick();
        end
        drive_idle();
        assert (strobe_cnt == 75)
        else flag_failure($sformatf("dump had %0d strobes instead of 75", strobe_cnt));
        assert (exp_q.size() == 0) else flag_failure("dump ended with characters missing");
        assert (c_reads == 16)
        else flag_failure($sformatf("register C was read %0d times, not 16", c_reads));
    endtask

    // decoded instruction without phase 3 and then phase 3 without clock enable.
    task automatic check_no_start();
        clk_en        = 1'b1;
        phases        = 4'b0111;
        instr_decoded = 1'b1;
        repeat (6) begin
            tick();
            assert (!debug_cycle) else flag_failure("cycle started without phase 3");
        end
        clk_en = 1'b0;
        phases = 4'b1000;
        repeat (6) begin
            tick();
            assert (!debug_cycle) else flag_failure("cycle started without clock enable");
        end
        drive_idle();
        tick();
    endtask

    initial begin
        seed           = 98928;
        mismatch_count = 0;
        failure_count  = 0;
        strobe_cnt     = 0;
        c_reads        = 0;
        exp_ptr        = 4'hf;
        current_pc     = '0;
        carry          = 1'b0;
        reg_p          = '0;
        reg_hst        = '0;
        reg_st         = '0;
        c_value        = '0;
        reset          = 1'b1;
        drive_idle();

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        tick();
        assert (!debug_cycle && !char_strobe && dbg_register == ALU_REG_NONE
                && char_to_send == 8'h00)
        else flag_failure("outputs are not idle after reset");

        run_dump(1'b0, 1'b0);
        run_dump(1'b0, 1'b1);
        check_no_start();
        run_dump(1'b1, 1'b0);
        run_dump(1'b1, 1'b1);
        repeat (4) tick();

        $display("mismatches: %0d, other errors: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog sized for the dumps above at the slowest clock enable rate.
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish in %0d clock cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
